//--- hw/icache_settings.svh
// **********************************************************
// icache geometry macros
// cacop code values
// **********************************************************
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// address split: tag, index, byte offset
`define ICACHE_TAG_W        20
`define ICACHE_IDX_W        8
`define ICACHE_OFS_W        4

`define ICACHE_WAYS         2

// four 32-bit words per line
`define ICACHE_BEATS        4
`define ICACHE_LINE_W       128

// cacop code field
`define ICACHE_CACOP_INIT   2'd0
`define ICACHE_CACOP_INDEX  2'd1
`define ICACHE_CACOP_HIT    2'd2

`endif

//--- hw/icache_pkg.sv
// **********************************************************
// icache types: cpu request/response, bridge channels,
// decoded operation, opcode and state enums
// **********************************************************
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

    typedef struct packed {
        logic [31:0] addr;
        logic        uncached;
        logic        cacop_en;
        logic [1:0]  cacop_code;
    } icache_req_t;

    typedef struct packed {
        logic [`ICACHE_LINE_W-1:0] data;
    } icache_resp_t;

    // always a line burst, address line aligned
    typedef struct packed {
        logic [31:0] addr;
    } bridge_req_t;

    typedef struct packed {
        logic        ret_valid;
        logic        ret_last;
        logic [31:0] ret_data;
    } bridge_ret_t;

    typedef enum logic [2:0] {
        op_fetch,
        op_fetch_uncached,
        op_inv_index,
        op_inv_hit,
        op_none
    } icache_op_e;

    typedef struct packed {
        icache_op_e               op;
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [`ICACHE_IDX_W-1:0] idx;
        logic                     way;
    } icache_dec_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_request,
        st_receive,
        st_invalidate
    } icache_state_e;

endpackage

`default_nettype wire

//--- hw/icache_req_decode.sv
// **********************************************************
// request decode: address split, cacop to opcode mapping
// request buffer loaded on accept
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_req_decode (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire icache_pkg::icache_req_t  req_i,
    input  wire logic                     accept_i,
    output icache_pkg::icache_dec_t       dec_o,
    output icache_pkg::icache_dec_t       dec_now_o
);

    // decode of the request on the bus, used for the idle-cycle array access
    always_comb begin
        dec_now_o.tag = req_i.addr[31 -: `ICACHE_TAG_W];
        dec_now_o.idx = req_i.addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
        // index ops name the way by the lowest address bit
        dec_now_o.way = req_i.addr[0];

        // cacop wins over the fetch
        if (req_i.cacop_en) begin
            case (req_i.cacop_code)
                `ICACHE_CACOP_INIT,
                `ICACHE_CACOP_INDEX: dec_now_o.op = icache_pkg::op_inv_index;
                `ICACHE_CACOP_HIT:   dec_now_o.op = icache_pkg::op_inv_hit;
                default:             dec_now_o.op = icache_pkg::op_none;
            endcase
        end else if (req_i.uncached) begin
            dec_now_o.op = icache_pkg::op_fetch_uncached;
        end else begin
            dec_now_o.op = icache_pkg::op_fetch;
        end
    end

    // request buffer
    always_ff @(posedge clock) begin
        if (reset) begin
            dec_o.op <= icache_pkg::op_none;
        end else if (accept_i) begin
            dec_o.op <= dec_now_o.op;
        end
    end

    always_ff @(posedge clock) begin
        if (accept_i) begin
            dec_o.tag <= dec_now_o.tag;
            dec_o.idx <= dec_now_o.idx;
            dec_o.way <= dec_now_o.way;
        end
    end

endmodule

`default_nettype wire

//--- hw/icache_way_store.sv
// **********************************************************
// two-way tag/valid and data arrays, per-set lru bits
// hit detection, hit line select, victim choice
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_way_store (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire logic                       rd_en_i,
    input  wire logic [`ICACHE_IDX_W-1:0]   rd_idx_i,
    input  wire logic                       inv_en_i,
    input  wire logic [`ICACHE_IDX_W-1:0]   inv_idx_i,
    input  wire logic                       inv_way_i,
    input  wire logic                       fill_en_i,
    input  wire icache_pkg::icache_dec_t    fill_dec_i,
    input  wire logic [`ICACHE_LINE_W-1:0]  fill_line_i,
    input  wire logic [`ICACHE_TAG_W-1:0]   cmp_tag_i,
    output logic                            hit_o,
    output logic                            hit_way_o,
    output logic [`ICACHE_LINE_W-1:0]       hit_line_o,
    input  wire logic                       touch_i
);

    localparam int num_sets = 1 << `ICACHE_IDX_W;

    logic [`ICACHE_TAG_W-1:0]  tag_mem   [`ICACHE_WAYS][num_sets];
    logic [`ICACHE_LINE_W-1:0] data_mem  [`ICACHE_WAYS][num_sets];
    logic [num_sets-1:0]       valid_q   [`ICACHE_WAYS];
    // lru bit names the way to replace next
    logic [num_sets-1:0]       lru_q;

    logic [`ICACHE_TAG_W-1:0]  rd_tag_q  [`ICACHE_WAYS];
    logic [`ICACHE_LINE_W-1:0] rd_line_q [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]   rd_valid_q;
    logic [`ICACHE_IDX_W-1:0]  rd_idx_q;
    logic [`ICACHE_WAYS-1:0]   way_hit;
    logic                      victim;

    // **********************************************************
    // arrays
    // **********************************************************
    always_ff @(posedge clock) begin
        if (rd_en_i) begin
            rd_idx_q <= rd_idx_i;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                rd_tag_q[w]  <= tag_mem[w][rd_idx_i];
                rd_line_q[w] <= data_mem[w][rd_idx_i];
            end
        end
        if (fill_en_i) begin
            tag_mem[victim][fill_dec_i.idx]  <= fill_dec_i.tag;
            data_mem[victim][fill_dec_i.idx] <= fill_line_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            rd_valid_q <= '0;
            lru_q      <= '0;
        end else begin
            if (rd_en_i) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    rd_valid_q[w] <= valid_q[w][rd_idx_i];
                end
            end
            if (fill_en_i) begin
                valid_q[victim][fill_dec_i.idx] <= 1'b1;
                lru_q[fill_dec_i.idx]           <= ~victim;
            end
            if (inv_en_i) begin
                valid_q[inv_way_i][inv_idx_i] <= 1'b0;
            end
            if (touch_i) begin
                lru_q[rd_idx_q] <= ~hit_way_o;
            end
        end
    end

    // **********************************************************
    // hit and victim
    // **********************************************************
    always_comb begin
        hit_line_o = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = rd_valid_q[w] && (rd_tag_q[w] == cmp_tag_i);
            hit_line_o = hit_line_o | ({`ICACHE_LINE_W{way_hit[w]}} & rd_line_q[w]);
        end
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // invalid way first, way 0 before way 1, else lru
    always_comb begin
        if (!valid_q[0][fill_dec_i.idx]) begin
            victim = 1'b0;
        end else if (!valid_q[1][fill_dec_i.idx]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[fill_dec_i.idx];
        end
    end

    a_no_fill_and_inv: assert property (
        @(posedge clock) disable iff (reset) !(fill_en_i && inv_en_i)
    );

endmodule

`default_nettype wire

//--- hw/icache_refill.sv
// **********************************************************
// refill buffer: collects bridge beats into one line
// and flags the last beat
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_refill (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     collect_i,
    input  wire icache_pkg::bridge_ret_t  ret_i,
    output logic [`ICACHE_LINE_W-1:0]     line_o,
    output logic                          done_o
);

    localparam int cnt_w = $clog2(`ICACHE_BEATS);

    logic [cnt_w-1:0] beat_cnt_q;
    logic [31:0]      word_q [`ICACHE_BEATS-1];
    logic             last_beat;
    logic             beat;

    assign beat      = collect_i && ret_i.ret_valid;
    assign last_beat = ret_i.ret_last || (beat_cnt_q == cnt_w'(`ICACHE_BEATS - 1));
    assign done_o    = beat && last_beat;

    always_ff @(posedge clock) begin
        if (reset) begin
            beat_cnt_q <= '0;
        end else if (!collect_i || done_o) begin
            beat_cnt_q <= '0;
        end else if (beat) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    // last word is never stored, it goes straight out
    always_ff @(posedge clock) begin
        if (beat && !last_beat) begin
            word_q[beat_cnt_q] <= ret_i.ret_data;
        end
    end

    // beat 0 lands in the lowest word
    always_comb begin
        line_o[`ICACHE_LINE_W-1 -: 32] = ret_i.ret_data;
        for (int k = 0; k < `ICACHE_BEATS - 1; k++) begin
            line_o[k*32 +: 32] = word_q[k];
        end
    end

    a_ret_in_collect: assert property (
        @(posedge clock) disable iff (reset) ret_i.ret_valid |-> collect_i
    );

endmodule

`default_nettype wire

//--- hw/icache_ctrl.sv
// **********************************************************
// control FSM: idle, lookup, request, receive, invalidate
// array enables and response timing
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     req_valid_i,
    input  wire icache_pkg::icache_dec_t  dec_i,
    input  wire icache_pkg::icache_dec_t  dec_now_i,
    input  wire logic                     hit_i,
    input  wire logic                     refill_done_i,
    output logic                          req_ready_o,
    output logic                          accept_o,
    output logic                          rd_req_o,
    input  wire logic                     rd_rdy_i,
    output logic                          lookup_en_o,
    output logic                          inv_en_o,
    output logic                          fill_en_o,
    output logic                          touch_o,
    output logic                          collect_o,
    output logic                          resp_valid_o,
    output logic                          resp_from_refill_o
);

    icache_pkg::icache_state_e state_q;
    icache_pkg::icache_state_e state_d;

    logic in_idle;
    logic in_lookup;
    logic in_receive;
    logic buf_fetch;

    assign in_idle    = (state_q == icache_pkg::st_idle);
    assign in_lookup  = (state_q == icache_pkg::st_lookup);
    assign in_receive = (state_q == icache_pkg::st_receive);
    assign buf_fetch  = (dec_i.op == icache_pkg::op_fetch);

    // **********************************************************
    // next state
    // **********************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::st_idle: begin
                if (accept_o) begin
                    case (dec_now_i.op)
                        icache_pkg::op_fetch,
                        icache_pkg::op_inv_hit:        state_d = icache_pkg::st_lookup;
                        icache_pkg::op_fetch_uncached: state_d = icache_pkg::st_request;
                        // index invalidate is done at the accept edge
                        default:                       state_d = icache_pkg::st_idle;
                    endcase
                end
            end
            icache_pkg::st_lookup: begin
                if (dec_i.op == icache_pkg::op_inv_hit) begin
                    state_d = icache_pkg::st_invalidate;
                end else if (hit_i) begin
                    state_d = icache_pkg::st_idle;
                end else begin
                    state_d = icache_pkg::st_request;
                end
            end
            icache_pkg::st_request: begin
                if (rd_rdy_i) begin
                    state_d = icache_pkg::st_receive;
                end
            end
            icache_pkg::st_receive: begin
                if (refill_done_i) begin
                    state_d = icache_pkg::st_idle;
                end
            end
            default: begin
                state_d = icache_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= icache_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // **********************************************************
    // outputs
    // **********************************************************
    assign req_ready_o = in_idle;
    assign accept_o    = in_idle && req_valid_i;
    assign rd_req_o    = (state_q == icache_pkg::st_request);
    assign collect_o   = in_receive;

    assign lookup_en_o = accept_o && (dec_now_i.op == icache_pkg::op_fetch
                                   || dec_now_i.op == icache_pkg::op_inv_hit);

    assign inv_en_o = (accept_o && dec_now_i.op == icache_pkg::op_inv_index)
                   || (state_q == icache_pkg::st_invalidate && hit_i);

    // uncached refills bypass the arrays
    assign fill_en_o = in_receive && refill_done_i && buf_fetch;
    assign touch_o   = in_lookup && buf_fetch && hit_i;

    assign resp_valid_o       = touch_o || (in_receive && refill_done_i);
    assign resp_from_refill_o = in_receive;

    // bridge address comes from the request buffer, held until rd_rdy
    a_rd_req_hold: assert property (
        @(posedge clock) disable iff (reset)
        rd_req_o && !rd_rdy_i |=> rd_req_o && $stable(dec_i.tag) && $stable(dec_i.idx)
    );

endmodule

`default_nettype wire

//--- hw/icache.sv
// **********************************************************
// icache top: decode, way store, refill and control
// cpu request channel and read bridge
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     req_valid_i,
    output logic                          req_ready_o,
    input  wire icache_pkg::icache_req_t  req_i,
    output logic                          resp_valid_o,
    output icache_pkg::icache_resp_t      resp_o,
    output logic                          rd_req_o,
    output icache_pkg::bridge_req_t       rd_addr_o,
    input  wire logic                     rd_rdy_i,
    input  wire icache_pkg::bridge_ret_t  ret_i
);

    icache_pkg::icache_dec_t   dec;
    icache_pkg::icache_dec_t   dec_now;
    logic                      accept;
    logic                      lookup_en;
    logic                      inv_en;
    logic                      fill_en;
    logic                      touch;
    logic                      collect;
    logic                      resp_from_refill;
    logic                      hit;
    logic                      hit_way;
    logic [`ICACHE_LINE_W-1:0] hit_line;
    logic [`ICACHE_LINE_W-1:0] refill_line;
    logic                      refill_done;
    logic [`ICACHE_IDX_W-1:0]  inv_idx;
    logic                      inv_way;

    // index invalidate acts on the bus request, hit invalidate on the buffer
    assign inv_idx = accept ? dec_now.idx : dec.idx;
    assign inv_way = accept ? dec_now.way : hit_way;

    assign rd_addr_o.addr = {dec.tag, dec.idx, {`ICACHE_OFS_W{1'b0}}};
    assign resp_o.data    = resp_from_refill ? refill_line : hit_line;

    icache_req_decode u_decode (
        .clock      (clock),
        .reset      (reset),
        .req_i      (req_i),
        .accept_i   (accept),
        .dec_o      (dec),
        .dec_now_o  (dec_now)
    );

    icache_way_store u_way_store (
        .clock        (clock),
        .reset        (reset),
        .rd_en_i      (lookup_en),
        .rd_idx_i     (dec_now.idx),
        .inv_en_i     (inv_en),
        .inv_idx_i    (inv_idx),
        .inv_way_i    (inv_way),
        .fill_en_i    (fill_en),
        .fill_dec_i   (dec),
        .fill_line_i  (refill_line),
        .cmp_tag_i    (dec.tag),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .hit_line_o   (hit_line),
        .touch_i      (touch)
    );

    icache_refill u_refill (
        .clock      (clock),
        .reset      (reset),
        .collect_i  (collect),
        .ret_i      (ret_i),
        .line_o     (refill_line),
        .done_o     (refill_done)
    );

    icache_ctrl u_ctrl (
        .clock               (clock),
        .reset               (reset),
        .req_valid_i         (req_valid_i),
        .dec_i               (dec),
        .dec_now_i           (dec_now),
        .hit_i               (hit),
        .refill_done_i       (refill_done),
        .req_ready_o         (req_ready_o),
        .accept_o            (accept),
        .rd_req_o            (rd_req_o),
        .rd_rdy_i            (rd_rdy_i),
        .lookup_en_o         (lookup_en),
        .inv_en_o            (inv_en),
        .fill_en_o           (fill_en),
        .touch_o             (touch),
        .collect_o           (collect),
        .resp_valid_o        (resp_valid_o),
        .resp_from_refill_o  (resp_from_refill)
    );

endmodule

`default_nettype wire

//--- sim/icache_tb_bridge.sv
// **********************************************************
// read bridge model: random rd_rdy and beat stalls,
// returns a line whose word k is line address plus k
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module icache_tb_bridge (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     rd_req_i,
    input  wire icache_pkg::bridge_req_t  rd_addr_i,
    output logic                          rd_rdy_o,
    output icache_pkg::bridge_ret_t       ret_o,
    output int                            req_count_o,
    output logic [31:0]                   last_addr_o,
    output logic                          overlap_o
);

    logic [31:0] lfsr_q;
    logic        busy_q;
    int          beat_q;

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per stall bit
    task automatic take_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);
        b = lfsr_q[0];
    endtask

    initial begin
        lfsr_q      = 32'h3c59;
        busy_q      = 1'b0;
        beat_q      = 0;
        rd_rdy_o    = 1'b0;
        ret_o       = '0;
        req_count_o = 0;
        last_addr_o = '0;
        overlap_o   = 1'b0;
    end

    // everything moves on the falling edge, the cache samples on the rising one
    always @(negedge clock) begin
        logic go;
        if (reset) begin
            lfsr_q      = 32'h3c59;
            busy_q      = 1'b0;
            beat_q      = 0;
            rd_rdy_o    = 1'b0;
            ret_o       = '0;
            req_count_o = 0;
            overlap_o   = 1'b0;
        end else begin
            ret_o = '0;
            if (rd_rdy_o) begin
                // handshake took place at the last rising edge
                rd_rdy_o = 1'b0;
                busy_q   = 1'b1;
                beat_q   = 0;
                req_count_o++;
            end else if (busy_q) begin
                if (rd_req_i) begin
                    overlap_o = 1'b1;
                end
                take_bit(go);
                if (go) begin
                    ret_o.ret_valid = 1'b1;
                    ret_o.ret_last  = (beat_q == 3);
                    ret_o.ret_data  = last_addr_o + beat_q;
                    busy_q          = (beat_q != 3);
                    beat_q++;
                end
            end else if (rd_req_i) begin
                take_bit(go);
                if (go) begin
                    rd_rdy_o    = 1'b1;
                    last_addr_o = rd_addr_i.addr;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/icache_tb.sv
// **********************************************************
// icache testbench: clock, reset, bridge model,
// directed fetch and cacop tests with checks
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_tb;

    localparam int wait_limit = 200;

    logic                     clock;
    logic                     reset;
    logic                     req_valid;
    icache_pkg::icache_req_t  req;
    logic                     req_ready;
    logic                     resp_valid;
    icache_pkg::icache_resp_t resp;
    logic                     rd_req;
    icache_pkg::bridge_req_t  rd_addr;
    logic                     rd_rdy;
    icache_pkg::bridge_ret_t  ret;
    int                       bridge_reqs;
    logic [31:0]              bridge_addr;
    logic                     bridge_overlap;
    int                       mismatch_count;
    int                       failure_count;

    icache u_icache (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_i        (req),
        .resp_valid_o (resp_valid),
        .resp_o       (resp),
        .rd_req_o     (rd_req),
        .rd_addr_o    (rd_addr),
        .rd_rdy_i     (rd_rdy),
        .ret_i        (ret)
    );

    icache_tb_bridge u_bridge (
        .clock        (clock),
        .reset        (reset),
        .rd_req_i     (rd_req),
        .rd_addr_i    (rd_addr),
        .rd_rdy_o     (rd_rdy),
        .ret_o        (ret),
        .req_count_o  (bridge_reqs),
        .last_addr_o  (bridge_addr),
        .overlap_o    (bridge_overlap)
    );

    always #10 clock = ~clock;

    // word k of a line holds the line address plus k, word 0 lowest
    function automatic logic [`ICACHE_LINE_W-1:0] expected_line(input logic [31:0] addr);
        logic [31:0]               base;
        logic [`ICACHE_LINE_W-1:0] line;
        base = {addr[31:4], 4'h0};
        for (int k = 0; k < `ICACHE_BEATS; k++) begin
            line[k*32 +: 32] = base + k;
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
            mismatch_count++;
        end
    endtask

    // drive on the falling edge, return once the request is taken
    task automatic send_req(input icache_pkg::icache_req_t r);
        int cycles;
        logic taken;
        cycles = 0;
        taken  = 1'b0;
        @(negedge clock);
        req_valid = 1'b1;
        req       = r;
        while (!taken && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
            taken = req_ready;
        end
        @(negedge clock);
        req_valid = 1'b0;
        assert (taken) else begin
            $display("timeout at %0t ns: request for %h never accepted", $time, r.addr);
            failure_count++;
        end
    endtask

    task automatic fetch(input logic [31:0] addr, input logic uncached, input logic exp_hit);
        icache_pkg::icache_req_t  r;
        int                       reqs_before;
        int                       cycles;
        logic                     got;
        logic [`ICACHE_LINE_W-1:0] line;
        r.addr       = addr;
        r.uncached   = uncached;
        r.cacop_en   = 1'b0;
        r.cacop_code = 2'd0;
        reqs_before  = bridge_reqs;
        cycles       = 0;
        got          = 1'b0;
        send_req(r);
        // the first rising edge after acceptance is already behind us
        cycles = 1;
        check_value("req_ready_o", 128'(req_ready), 128'd0);
        if (resp_valid) begin
            got  = 1'b1;
            line = resp.data;
        end
        while (!got && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
            // busy until the response cycle is over
            check_value("req_ready_o", 128'(req_ready), 128'd0);
            if (resp_valid) begin
                got  = 1'b1;
                line = resp.data;
            end
        end
        if (!got) begin
            $display("timeout at %0t ns: no response to fetch of %h", $time, addr);
            failure_count++;
        end else begin
            check_value("resp_o", line, expected_line(addr));
            if (exp_hit) begin
                check_value("hit latency", 128'(cycles), 128'd1);
                check_value("bridge requests", 128'(bridge_reqs), 128'(reqs_before));
            end else begin
                check_value("bridge requests", 128'(bridge_reqs), 128'(reqs_before + 1));
                check_value("rd_addr_o", 128'(bridge_addr), 128'({addr[31:4], 4'h0}));
            end
            // one-cycle response, ready again in the next cycle
            @(negedge clock);
            check_value("req_ready_o", 128'(req_ready), 128'd1);
            check_value("resp_valid_o", 128'(resp_valid), 128'd0);
        end
    endtask

    task automatic cacop(input logic [1:0] code, input logic [31:0] addr);
        icache_pkg::icache_req_t r;
        int                      cycles;
        logic                    idle;
        r.addr       = addr;
        r.uncached   = 1'b0;
        r.cacop_en   = 1'b1;
        r.cacop_code = code;
        cycles       = 1;
        send_req(r);
        idle = req_ready;
        while (!idle && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
            assert (!resp_valid) else begin
                $display("a cacop at %0t ns produced a response", $time);
                failure_count++;
            end
            idle = req_ready;
        end
        assert (idle) else begin
            $display("timeout at %0t ns: cache stuck after cacop on %h", $time, addr);
            failure_count++;
        end
    endtask

    // ********************************************************
    // directed tests
    // ********************************************************
    task automatic test_cold_then_hit();
        fetch(32'h0040_0340, 1'b0, 1'b0);
        fetch(32'h0040_0348, 1'b0, 1'b1);
    endtask

    task automatic test_uncached();
        fetch(32'h0050_0560, 1'b1, 1'b0);
        fetch(32'h0050_0564, 1'b1, 1'b0);
        fetch(32'h0050_0560, 1'b0, 1'b0);
        fetch(32'h0050_0560, 1'b0, 1'b1);
    endtask

    // lines a, b, c all map to set 0x12
    task automatic test_lru_replace();
        fetch(32'h0001_0120, 1'b0, 1'b0);
        fetch(32'h0002_0120, 1'b0, 1'b0);
        fetch(32'h0001_0120, 1'b0, 1'b1);
        fetch(32'h0003_0120, 1'b0, 1'b0);
        fetch(32'h0001_0120, 1'b0, 1'b1);
        fetch(32'h0002_0120, 1'b0, 1'b0);
    endtask

    // way 0 holds a, way 1 holds b; address bit 0 names the way
    task automatic test_index_invalidate();
        cacop(`ICACHE_CACOP_INDEX, 32'h0000_0120);
        fetch(32'h0002_0120, 1'b0, 1'b1);
        fetch(32'h0001_0120, 1'b0, 1'b0);
        cacop(`ICACHE_CACOP_INIT, 32'h0000_0121);
        fetch(32'h0001_0120, 1'b0, 1'b1);
        fetch(32'h0002_0120, 1'b0, 1'b0);
    endtask

    task automatic test_hit_invalidate();
        fetch(32'h0040_0340, 1'b0, 1'b1);
        cacop(`ICACHE_CACOP_HIT, 32'h0040_0340);
        fetch(32'h0040_0340, 1'b0, 1'b0);
        cacop(`ICACHE_CACOP_HIT, 32'h0060_0340);
        fetch(32'h0040_0340, 1'b0, 1'b1);
    endtask

    task automatic test_bridge_stalls();
        logic [31:0] line_addr;
        for (int i = 0; i < 6; i++) begin
            line_addr = {20'h7a000 + 20'(i), 8'h80 + 8'(i), 4'h0};
            fetch(line_addr + 32'(4 * (i % 4)), 1'b0, 1'b0);
            fetch(line_addr + 32'h0100_0000, 1'b1, 1'b0);
            fetch(line_addr, 1'b0, 1'b1);
        end
        assert (!bridge_overlap) else begin
            $display("bridge saw rd_req_o while a refill was still in progress");
            failure_count++;
        end
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        mismatch_count = 0;
        failure_count  = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_cold_then_hit();
        test_uncached();
        test_lru_replace();
        test_index_invalidate();
        test_hit_invalidate();
        test_bridge_stalls();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- icache.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_req_decode.sv
hw/icache_way_store.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache.sv
sim/icache_tb_bridge.sv
sim/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the icache testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_tb -f icache.f -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
